// File: rtl/axiLitePkg.sv
`default_nettype none

package axiLitePkg;

  // AXI response codes used by this slave
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } respT;

  // default bus geometry
  localparam int defaultAddrWidth = 12;
  localparam int defaultDataWidth = 32; // 32 or 64

  // read/write registers below the ID word
  localparam int defaultNumRegs = 16;

  // identification word, sits at word index numRegs
  localparam logic [31:0] idWord = 32'h4A1C_0100;

endpackage : axiLitePkg

`default_nettype wire

// File: rtl/axiLiteWriteChannel.sv
`default_nettype none

module axiLiteWriteChannel #(
  parameter int addrWidth = 12,
  parameter int dataWidth = 32
) (
  input  logic                   aclk,
  input  logic                   arstN,

  // write address
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [addrWidth-1:0]   awaddr,

  // write data
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [dataWidth-1:0]   wdata,
  input  logic [dataWidth/8-1:0] wstrb,

  // write response
  output logic                   bvalid,
  input  logic                   bready,
  output axiLitePkg::respT       bresp,

  // register bank write port
  output logic                   regWrEn,
  output logic [addrWidth-1:0]   regWrAddr,
  output logic [dataWidth-1:0]   regWrData,
  output logic [dataWidth/8-1:0] regWrStrb,
  input  logic                   regWrErr
);

  logic                   awHeld;
  logic                   wHeld;
  logic [addrWidth-1:0]   awAddrQ;
  logic [dataWidth-1:0]   wDataQ;
  logic [dataWidth/8-1:0] wStrbQ;

  assign awready = ~awHeld;
  assign wready  = ~wHeld;

  // fire once both halves are in and no response is pending
  assign regWrEn   = awHeld & wHeld & ~bvalid;
  assign regWrAddr = awAddrQ;
  assign regWrData = wDataQ;
  assign regWrStrb = wStrbQ;

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      awHeld <= 1'b0;
      wHeld  <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        awHeld <= 1'b1;
      end else if (bvalid && bready) begin
        awHeld <= 1'b0; // freed only when B is taken
      end
      if (wvalid && wready) begin
        wHeld <= 1'b1;
      end else if (bvalid && bready) begin
        wHeld <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (awvalid && awready) begin
      awAddrQ <= awaddr;
    end
    if (wvalid && wready) begin
      wDataQ <= wdata;
      wStrbQ <= wstrb;
    end
  end

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      bvalid <= 1'b0;
    end else if (regWrEn) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (regWrEn) begin
      bresp <= regWrErr ? axiLitePkg::SLVERR : axiLitePkg::OKAY;
    end
  end

endmodule : axiLiteWriteChannel

`default_nettype wire

// File: rtl/axiLiteReadChannel.sv
`default_nettype none

module axiLiteReadChannel #(
  parameter int addrWidth = 12,
  parameter int dataWidth = 32
) (
  input  logic                 aclk,
  input  logic                 arstN,

  // read address
  input  logic                 arvalid,
  output logic                 arready,
  input  logic [addrWidth-1:0] araddr,

  // read data
  output logic                 rvalid,
  input  logic                 rready,
  output logic [dataWidth-1:0] rdata,
  output axiLitePkg::respT     rresp,

  // register bank read port
  output logic [addrWidth-1:0] regRdAddr,
  input  logic [dataWidth-1:0] regRdData,
  input  logic                 regRdErr
);

  logic [addrWidth-1:0] arAddrQ;
  logic                 arFire;

  assign arready = ~rvalid; // one read in flight
  assign arFire  = arvalid & arready;

  // bank looks at the live address while idle, the accepted one while R is held
  assign regRdAddr = rvalid ? arAddrQ : araddr;

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      rvalid <= 1'b0;
    end else if (arFire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // data and response sampled on the AR edge, stable until taken
  always_ff @(posedge aclk) begin
    if (arFire) begin
      arAddrQ <= araddr;
      rdata   <= regRdData;
      rresp   <= regRdErr ? axiLitePkg::SLVERR : axiLitePkg::OKAY;
    end
  end

endmodule : axiLiteReadChannel

`default_nettype wire

// File: rtl/axiLiteRegBank.sv
`default_nettype none

module axiLiteRegBank #(
  parameter int addrWidth = 12,
  parameter int dataWidth = 32,
  parameter int numRegs   = 16
) (
  input  logic                   aclk,
  input  logic                   arstN,

  // write port
  input  logic                   regWrEn,
  input  logic [addrWidth-1:0]   regWrAddr,
  input  logic [dataWidth-1:0]   regWrData,
  input  logic [dataWidth/8-1:0] regWrStrb,
  output logic                   regWrErr,

  // read port
  input  logic [addrWidth-1:0]   regRdAddr,
  output logic [dataWidth-1:0]   regRdData,
  output logic                   regRdErr
);

  localparam int bytesPerWord = dataWidth / 8;
  localparam int byteLsbs     = $clog2(bytesPerWord);
  localparam int wordIdxW     = addrWidth - byteLsbs;
  localparam int regSelW      = (numRegs > 1) ? $clog2(numRegs) : 1;

  logic [dataWidth-1:0] regs [numRegs];

  logic [wordIdxW-1:0]  wrIdx;
  logic [wordIdxW-1:0]  rdIdx;
  logic [regSelW-1:0]   wrSel;
  logic [regSelW-1:0]   rdSel;
  logic                 wrHit;
  logic [dataWidth-1:0] wrMerged;

  // word index, byte offset dropped
  assign wrIdx = regWrAddr[addrWidth-1:byteLsbs];
  assign rdIdx = regRdAddr[addrWidth-1:byteLsbs];
  assign wrSel = wrIdx[regSelW-1:0];
  assign rdSel = rdIdx[regSelW-1:0];

  assign wrHit    = wrIdx < wordIdxW'(numRegs);
  assign regWrErr = ~wrHit; // ID word and holes refuse writes

  always_comb begin
    wrMerged = regs[wrSel];
    for (int b = 0; b < bytesPerWord; b++) begin
      if (regWrStrb[b]) begin
        wrMerged[8*b +: 8] = regWrData[8*b +: 8];
      end
    end
  end

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrEn && wrHit) begin
      regs[wrSel] <= wrMerged;
    end
  end

  always_comb begin
    regRdData = '0;
    regRdErr  = 1'b0;
    if (rdIdx < wordIdxW'(numRegs)) begin
      regRdData = regs[rdSel];
    end else if (rdIdx == wordIdxW'(numRegs)) begin
      regRdData = dataWidth'(axiLitePkg::idWord); // zero-extended on 64 bit
    end else begin
      regRdErr = 1'b1;
    end
  end

endmodule : axiLiteRegBank

`default_nettype wire

// File: rtl/axiLiteSlaveTop.sv
`default_nettype none

module axiLiteSlaveTop #(
  parameter int addrWidth = axiLitePkg::defaultAddrWidth,
  parameter int dataWidth = axiLitePkg::defaultDataWidth,
  parameter int numRegs   = axiLitePkg::defaultNumRegs
) (
  input  logic                   aclk,
  input  logic                   arstN,

  input  logic                   awvalid,
  output logic                   awready,
  input  logic [addrWidth-1:0]   awaddr,

  input  logic                   wvalid,
  output logic                   wready,
  input  logic [dataWidth-1:0]   wdata,
  input  logic [dataWidth/8-1:0] wstrb,

  output logic                   bvalid,
  input  logic                   bready,
  output axiLitePkg::respT       bresp,

  input  logic                   arvalid,
  output logic                   arready,
  input  logic [addrWidth-1:0]   araddr,

  output logic                   rvalid,
  input  logic                   rready,
  output logic [dataWidth-1:0]   rdata,
  output axiLitePkg::respT       rresp
);

  logic                   regWrEn;
  logic [addrWidth-1:0]   regWrAddr;
  logic [dataWidth-1:0]   regWrData;
  logic [dataWidth/8-1:0] regWrStrb;
  logic                   regWrErr;
  logic [addrWidth-1:0]   regRdAddr;
  logic [dataWidth-1:0]   regRdData;
  logic                   regRdErr;

  axiLiteWriteChannel #(
    .addrWidth(addrWidth),
    .dataWidth(dataWidth)
  ) writeChannel (
    .aclk     (aclk),
    .arstN    (arstN),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .regWrEn  (regWrEn),
    .regWrAddr(regWrAddr),
    .regWrData(regWrData),
    .regWrStrb(regWrStrb),
    .regWrErr (regWrErr)
  );

  axiLiteReadChannel #(
    .addrWidth(addrWidth),
    .dataWidth(dataWidth)
  ) readChannel (
    .aclk     (aclk),
    .arstN    (arstN),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .rresp    (rresp),
    .regRdAddr(regRdAddr),
    .regRdData(regRdData),
    .regRdErr (regRdErr)
  );

  axiLiteRegBank #(
    .addrWidth(addrWidth),
    .dataWidth(dataWidth),
    .numRegs  (numRegs)
  ) regBank (
    .aclk     (aclk),
    .arstN    (arstN),
    .regWrEn  (regWrEn),
    .regWrAddr(regWrAddr),
    .regWrData(regWrData),
    .regWrStrb(regWrStrb),
    .regWrErr (regWrErr),
    .regRdAddr(regRdAddr),
    .regRdData(regRdData),
    .regRdErr (regRdErr)
  );

endmodule : axiLiteSlaveTop

`default_nettype wire

// File: testbench/axiLiteMasterBfm.sv
`default_nettype none

module axiLiteMasterBfm #(
  parameter int addrWidth = 12,
  parameter int dataWidth = 32
) (
  input  logic                   aclk,
  output logic                   awvalid,
  input  logic                   awready,
  output logic [addrWidth-1:0]   awaddr,
  output logic                   wvalid,
  input  logic                   wready,
  output logic [dataWidth-1:0]   wdata,
  output logic [dataWidth/8-1:0] wstrb,
  input  logic                   bvalid,
  output logic                   bready,
  input  axiLitePkg::respT       bresp,
  output logic                   arvalid,
  input  logic                   arready,
  output logic [addrWidth-1:0]   araddr,
  input  logic                   rvalid,
  output logic                   rready,
  input  logic [dataWidth-1:0]   rdata,
  input  axiLitePkg::respT       rresp
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int txnLimit = 20; // cycles a transaction may take

  logic [15:0] lfsrState;
  int          spent; // cycles waited in the current transaction

  initial begin
    lfsrState = 16'd28;
    awvalid   <= 1'b0;
    awaddr    <= '0;
    wvalid    <= 1'b0;
    wdata     <= '0;
    wstrb     <= '0;
    bready    <= 1'b0;
    arvalid   <= 1'b0;
    araddr    <= '0;
    rready    <= 1'b0;
  end

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois, x^16+x^14+x^13+x^11+1
  endfunction

  // 0 to 3 idle cycles, one lfsr step per bit
  function automatic logic [1:0] randomDelay();
    logic [1:0] n;
    n = '0;
    for (int i = 0; i < 2; i++) begin
      lfsrState = lfsrNext(lfsrState);
      n = {n[0], lfsrState[0]};
    end
    return n;
  endfunction

  task automatic writeTxn(
    input  logic [addrWidth-1:0]   addr,
    input  logic [dataWidth-1:0]   data,
    input  logic [dataWidth/8-1:0] strb,
    output axiLitePkg::respT       resp,
    output bit                     late
  );
    spent  = 0;
    awaddr <= addr; // payload set while valids are low
    wdata  <= data;
    wstrb  <= strb;
    fork
      begin
        repeat (randomDelay()) @(posedge aclk);
        awvalid <= 1'b1;
        do begin
          @(negedge aclk);
          spent++;
        end while (!awready && spent < txnLimit);
        @(posedge aclk); // AW transfer
        awvalid <= 1'b0;
      end
      begin
        repeat (randomDelay()) @(posedge aclk);
        wvalid <= 1'b1;
        do begin
          @(negedge aclk);
          spent++;
        end while (!wready && spent < txnLimit);
        @(posedge aclk); // W transfer
        wvalid <= 1'b0;
      end
    join
    repeat (randomDelay()) @(posedge aclk);
    bready <= 1'b1;
    do begin
      @(negedge aclk);
      spent++;
    end while (!bvalid && spent < txnLimit);
    resp = bresp; // stable, transfer on the next edge
    @(posedge aclk);
    bready <= 1'b0;
    late = spent >= txnLimit;
  endtask

  task automatic readTxn(
    input  logic [addrWidth-1:0] addr,
    output logic [dataWidth-1:0] data,
    output axiLitePkg::respT     resp,
    output bit                   late
  );
    spent  = 0;
    araddr <= addr;
    repeat (randomDelay()) @(posedge aclk);
    arvalid <= 1'b1;
    do begin
      @(negedge aclk);
      spent++;
    end while (!arready && spent < txnLimit);
    @(posedge aclk);
    arvalid <= 1'b0;
    repeat (randomDelay()) @(posedge aclk);
    rready <= 1'b1;
    do begin
      @(negedge aclk);
      spent++;
    end while (!rvalid && spent < txnLimit);
    data = rdata;
    resp = rresp;
    @(posedge aclk);
    rready <= 1'b0;
    late = spent >= txnLimit;
  endtask

endmodule : axiLiteMasterBfm

`default_nettype wire

// File: testbench/axiLiteHdlTop.sv
`default_nettype none

module axiLiteHdlTop;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int addrWidth   = 12;
  localparam int dataWidth   = 32;
  localparam int numRegs     = 16;
  localparam int maxPatterns = 128;

  logic                   aclk;
  logic                   arstN;
  logic                   awvalid;
  logic                   awready;
  logic [addrWidth-1:0]   awaddr;
  logic                   wvalid;
  logic                   wready;
  logic [dataWidth-1:0]   wdata;
  logic [dataWidth/8-1:0] wstrb;
  logic                   bvalid;
  logic                   bready;
  axiLitePkg::respT       bresp;
  logic                   arvalid;
  logic                   arready;
  logic [addrWidth-1:0]   araddr;
  logic                   rvalid;
  logic                   rready;
  logic [dataWidth-1:0]   rdata;
  axiLitePkg::respT       rresp;

  logic [7:0]             patOp    [maxPatterns];
  logic [addrWidth-1:0]   patAddr  [maxPatterns];
  logic [dataWidth-1:0]   patData  [maxPatterns];
  logic [dataWidth/8-1:0] patStrb  [maxPatterns];
  axiLitePkg::respT       patResp  [maxPatterns];
  logic [dataWidth-1:0]   patRdata [maxPatterns];

  int numPatterns;
  int cycles;
  int cycleLimit;
  int testsRun;
  int failCount;
  bit testOk;
  bit hung;

  axiLiteSlaveTop #(
    .addrWidth(addrWidth),
    .dataWidth(dataWidth),
    .numRegs  (numRegs)
  ) uut (.*);

  axiLiteMasterBfm #(
    .addrWidth(addrWidth),
    .dataWidth(dataWidth)
  ) bfm (.*);

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic checkResp(input string name, input axiLitePkg::respT exp,
                           input axiLitePkg::respT act);
    if (exp !== act) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      testOk = 1'b0;
    end
  endtask

  task automatic checkData(input string name, input logic [dataWidth-1:0] exp,
                           input logic [dataWidth-1:0] act);
    if (exp !== act) begin
      $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
      testOk = 1'b0;
    end
  endtask

  task automatic loadPatterns();
    int                     fd;
    int                     got;
    string                  line;
    logic [7:0]             op;
    logic [addrWidth-1:0]   addr;
    logic [dataWidth-1:0]   data;
    logic [dataWidth/8-1:0] strb;
    logic [1:0]             resp;
    logic [dataWidth-1:0]   rd;
    fd = $fopen("testbench/axiLitePatterns.txt", "r");
    if (fd == 0) begin
      $display("pattern file testbench/axiLitePatterns.txt could not be opened");
    end else begin
      while (!$feof(fd) && numPatterns < maxPatterns) begin
        got = $fgets(line, fd);
        if (got != 0) begin
          got = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, resp, rd);
          if (got == 6 && (op == "W" || op == "R")) begin // comment lines fall out here
            patOp[numPatterns]    = op;
            patAddr[numPatterns]  = addr;
            patData[numPatterns]  = data;
            patStrb[numPatterns]  = strb;
            patResp[numPatterns]  = axiLitePkg::respT'(resp);
            patRdata[numPatterns] = rd;
            numPatterns++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic runPattern(input int i);
    axiLitePkg::respT     resp;
    logic [dataWidth-1:0] data;
    bit                   late;
    testOk = 1'b1;
    if (patOp[i] == "W") begin
      bfm.writeTxn(patAddr[i], patData[i], patStrb[i], resp, late);
      if (!late) checkResp("bresp", patResp[i], resp);
    end else begin
      bfm.readTxn(patAddr[i], data, resp, late);
      if (!late) begin
        checkResp("rresp", patResp[i], resp);
        checkData("rdata", patRdata[i], data);
      end
    end
    testsRun++;
    if (late) begin
      $display("test %0d %c 0x%h did not complete within 20 cycles", i, patOp[i], patAddr[i]);
      hung = 1'b1;
      failCount++;
    end else begin
      $display("test %0d %c 0x%h %s", i, patOp[i], patAddr[i], testOk ? "passed" : "failed");
      if (!testOk) failCount++;
    end
  endtask

  initial begin
    arstN <= 1'b0;
    loadPatterns();
    cycleLimit = 30 * numPatterns + 50;
    if (numPatterns == 0) begin
      $display("no transactions were found in the pattern file");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      repeat (2) @(posedge aclk);
      arstN <= 1'b1;
      @(posedge aclk);
      for (int i = 0; i < numPatterns && !hung; i++) begin
        runPattern(i);
      end
      $display("%0d tests run, %0d passed, %0d failed", testsRun, testsRun - failCount,
               failCount);
      if (failCount == 0 && !hung) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule : axiLiteHdlTop

`default_nettype wire

// File: build.f
rtl/axiLitePkg.sv
rtl/axiLiteWriteChannel.sv
rtl/axiLiteReadChannel.sv
rtl/axiLiteRegBank.sv
rtl/axiLiteSlaveTop.sv
testbench/axiLiteMasterBfm.sv
testbench/axiLiteHdlTop.sv

// File: runSim.sh
#!/bin/sh
# builds the AXI4-Lite testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module axiLiteHdlTop \
  -f build.f -o simAxiLite
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/simAxiLite > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

// File: testbench/axiLitePatterns.txt
# op addr data strb resp rdata in hex
# resp 0 is OKAY and 2 is SLVERR and rdata is only compared on R lines
R 000 00000000 0 0 00000000
R 03C 00000000 0 0 00000000
W 000 C0DE0000 F 0 00000000
W 004 C0DE0101 F 0 00000000
W 008 C0DE0202 F 0 00000000
W 00C C0DE0303 F 0 00000000
W 010 C0DE0404 F 0 00000000
W 014 C0DE0505 F 0 00000000
W 018 C0DE0606 F 0 00000000
W 01C C0DE0707 F 0 00000000
W 020 C0DE0808 F 0 00000000
W 024 C0DE0909 F 0 00000000
W 028 C0DE0A0A F 0 00000000
W 02C C0DE0B0B F 0 00000000
W 030 C0DE0C0C F 0 00000000
W 034 C0DE0D0D F 0 00000000
W 038 C0DE0E0E F 0 00000000
W 03C C0DE0F0F F 0 00000000
R 000 00000000 0 0 C0DE0000
R 004 00000000 0 0 C0DE0101
R 008 00000000 0 0 C0DE0202
R 00C 00000000 0 0 C0DE0303
R 010 00000000 0 0 C0DE0404
R 014 00000000 0 0 C0DE0505
R 018 00000000 0 0 C0DE0606
R 01C 00000000 0 0 C0DE0707
R 020 00000000 0 0 C0DE0808
R 024 00000000 0 0 C0DE0909
R 028 00000000 0 0 C0DE0A0A
R 02C 00000000 0 0 C0DE0B0B
R 030 00000000 0 0 C0DE0C0C
R 034 00000000 0 0 C0DE0D0D
R 038 00000000 0 0 C0DE0E0E
R 03C 00000000 0 0 C0DE0F0F
W 008 11223344 1 0 00000000
R 008 00000000 0 0 C0DE0244
W 014 AABBCCDD A 0 00000000
R 014 00000000 0 0 AADECC05
W 024 12345678 6 0 00000000
R 024 00000000 0 0 C0345609
R 040 00000000 0 0 4A1C0100
W 040 DEADBEEF F 2 00000000
R 040 00000000 0 0 4A1C0100
W 044 12345678 F 2 00000000
R 004 00000000 0 0 C0DE0101
R 044 00000000 0 2 00000000
W 800 FFFFFFFF F 2 00000000
R 000 00000000 0 0 C0DE0000
R 800 00000000 0 2 00000000
R FFC 00000000 0 2 00000000
